/* rtl/tcm_pkg.sv */
// Common TCM types, bus widths and config register offsets, imported by the TCM modules
package tcm_pkg;

    // ------------------------------------------------------------
    // Core bus widths
    // ------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // ------------------------------------------------------------
    // Core memory interface encodings
    // ------------------------------------------------------------
    // Data port command
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    // Data port access width
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    // Response code, same on both ports
    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // Memory word seen either whole or as four byte lanes
    typedef union packed {
        logic [DATA_W-1:0]       word;
        logic [DATA_W/8-1:0][7:0] bytes;
    } tcm_word_u;

    // Configuration register offsets
    localparam logic [1:0] CFG_WP_LIMIT  = 2'd0;
    localparam logic [1:0] CFG_ERR_COUNT = 2'd1;

endpackage

/* rtl/tcm_sram_bank.sv */
// Behavioural dual-port SRAM bank, one read port for fetch and one byte-masked read/write port
`timescale 1ns/10ps

module tcm_sram_bank
    import tcm_pkg::*;
#(
    parameter int DEPTH = 512
) (
    input  logic                     clk,
    // Read-only port, instruction side
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [DATA_W-1:0]        rd_data,
    // Read/write port, data side
    input  logic                     rw_en,
    input  logic                     rw_we,
    input  logic [$clog2(DEPTH)-1:0] rw_addr,
    input  logic [3:0]               rw_mask,
    input  logic [DATA_W-1:0]        rw_wdata,
    output logic [DATA_W-1:0]        rw_rdata
);

    // Word array
    logic [DATA_W-1:0] mem [DEPTH];

    // Registered fetch read, holds last word when idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Data port, read sees the word before this cycle's write
    always_ff @(posedge clk) begin
        if (rw_en) begin
            rw_rdata <= mem[rw_addr];
            if (rw_we) begin
                for (int b = 0; b < 4; b++) begin
                    // Only masked lanes change
                    if (rw_mask[b]) begin
                        mem[rw_addr][8*b +: 8] <= rw_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

/* rtl/tcm_data_lane.sv */
// Data port lane logic for the TCM: store replication, byte enables, alignment and load shift
`timescale 1ns/10ps

module tcm_data_lane
    import tcm_pkg::*;
(
    // Request side
    input  mem_width_e        dmem_width,
    input  logic [1:0]        dmem_addr_lo,
    input  logic [DATA_W-1:0] dmem_wdata,
    output logic [DATA_W-1:0] wr_data,
    output logic [3:0]        wr_mask,
    output logic              misalign,
    // Response side
    input  logic [1:0]        resp_offset,
    input  logic [DATA_W-1:0] bank_rdata,
    output logic [DATA_W-1:0] dmem_rdata
);

    tcm_word_u src_w;
    tcm_word_u rep_w;

    // ------------------------------------------------------------
    // Store path
    // ------------------------------------------------------------
    always_comb begin
        src_w.word = dmem_wdata;
        rep_w.word = src_w.word;
        wr_mask    = 4'b1111;
        misalign   = 1'b0;
        case (dmem_width)
            MEM_WIDTH_BYTE: begin
                // Low byte copied to every lane
                for (int i = 0; i < 4; i++) begin
                    rep_w.bytes[i] = src_w.bytes[0];
                end
                wr_mask = 4'b0001 << dmem_addr_lo;
            end
            MEM_WIDTH_HWORD: begin
                // Low halfword into both halves
                for (int i = 0; i < 4; i++) begin
                    rep_w.bytes[i] = src_w.bytes[i % 2];
                end
                wr_mask  = 4'b0011 << {dmem_addr_lo[1], 1'b0};
                misalign = dmem_addr_lo[0];
            end
            MEM_WIDTH_WORD: begin
                misalign = |dmem_addr_lo;
            end
            default: begin
                // Unknown width, reject as misaligned
                wr_mask  = 4'b0000;
                misalign = 1'b1;
            end
        endcase
    end

    assign wr_data = rep_w.word;

    // ------------------------------------------------------------
    // Load path
    // ------------------------------------------------------------
    // Addressed lane moved down to bit 0, core does sign extension
    assign dmem_rdata = bank_rdata >> {resp_offset, 3'b000};

endmodule

/* rtl/tcm_access_ctrl.sv */
// TCM access control: checks core requests, drives bank enables and registers responses
`timescale 1ns/10ps

module tcm_access_ctrl
    import tcm_pkg::*;
#(
    parameter int TCM_SIZE = 4096
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // Core instruction port
    input  logic                       imem_req,
    input  logic [ADDR_W-1:0]          imem_addr,
    output logic                       imem_req_ack,
    output mem_resp_e                  imem_resp,
    output logic [DATA_W-1:0]          imem_rdata,
    // Core data port, control part
    input  logic                       dmem_req,
    input  mem_cmd_e                   dmem_cmd,
    input  logic [ADDR_W-1:0]          dmem_addr,
    output logic                       dmem_req_ack,
    output mem_resp_e                  dmem_resp,
    // Data lane
    input  logic                       misalign,
    input  logic [3:0]                 wr_mask,
    output logic [1:0]                 resp_offset,
    output logic [DATA_W-1:0]          bank_rdata,
    // Config block
    input  logic [ADDR_W-1:0]          wp_limit,
    output logic                       err_pulse,
    // Bank 0
    output logic                       bank0_rd_en,
    output logic [$clog2(TCM_SIZE)-4:0] bank0_rd_addr,
    input  logic [DATA_W-1:0]          bank0_rd_data,
    output logic                       bank0_rw_en,
    output logic                       bank0_rw_we,
    output logic [$clog2(TCM_SIZE)-4:0] bank0_rw_addr,
    output logic [3:0]                 bank0_rw_mask,
    input  logic [DATA_W-1:0]          bank0_rw_rdata,
    // Bank 1
    output logic                       bank1_rd_en,
    output logic [$clog2(TCM_SIZE)-4:0] bank1_rd_addr,
    input  logic [DATA_W-1:0]          bank1_rd_data,
    output logic                       bank1_rw_en,
    output logic                       bank1_rw_we,
    output logic [$clog2(TCM_SIZE)-4:0] bank1_rw_addr,
    output logic [3:0]                 bank1_rw_mask,
    input  logic [DATA_W-1:0]          bank1_rw_rdata
);

    // Top address bit inside the TCM picks the bank
    localparam int               BANK_BIT  = $clog2(TCM_SIZE) - 1;
    localparam logic [ADDR_W-1:0] TCM_LIMIT = ADDR_W'(TCM_SIZE);

    logic imem_ok;
    logic dmem_ok;
    logic dmem_wr;
    logic imem_bank_q;
    logic dmem_bank_q;

    // ------------------------------------------------------------
    // Request checks
    // ------------------------------------------------------------
    assign dmem_wr = (dmem_cmd == MEM_CMD_WR);

    // Fetch must be in range and word aligned
    assign imem_ok = imem_req && (imem_addr < TCM_LIMIT) && (imem_addr[1:0] == 2'b00);

    // Data must be in range, aligned, and writes above the protect limit
    assign dmem_ok = dmem_req && (dmem_addr < TCM_LIMIT) && !misalign
                  && !(dmem_wr && (dmem_addr < wp_limit));

    // One pulse per cycle with any rejected request
    assign err_pulse = (imem_req && !imem_ok) || (dmem_req && !dmem_ok);

    // Never stalls
    assign imem_req_ack = 1'b1;
    assign dmem_req_ack = 1'b1;

    // ------------------------------------------------------------
    // Bank control
    // ------------------------------------------------------------
    assign bank0_rd_en   = imem_ok && !imem_addr[BANK_BIT];
    assign bank1_rd_en   = imem_ok &&  imem_addr[BANK_BIT];
    assign bank0_rd_addr = imem_addr[BANK_BIT-1:2];
    assign bank1_rd_addr = imem_addr[BANK_BIT-1:2];

    assign bank0_rw_en   = dmem_ok && !dmem_addr[BANK_BIT];
    assign bank1_rw_en   = dmem_ok &&  dmem_addr[BANK_BIT];
    assign bank0_rw_we   = bank0_rw_en && dmem_wr;
    assign bank1_rw_we   = bank1_rw_en && dmem_wr;
    assign bank0_rw_addr = dmem_addr[BANK_BIT-1:2];
    assign bank1_rw_addr = dmem_addr[BANK_BIT-1:2];

    // Mask only reaches the bank being written
    assign bank0_rw_mask = bank0_rw_we ? wr_mask : 4'b0000;
    assign bank1_rw_mask = bank1_rw_we ? wr_mask : 4'b0000;

    // ------------------------------------------------------------
    // Response stage
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            imem_resp   <= MEM_RESP_NOTRDY;
            dmem_resp   <= MEM_RESP_NOTRDY;
            imem_bank_q <= 1'b0;
            dmem_bank_q <= 1'b0;
        end else begin
            // Idle cycle answers not ready
            if (imem_req) begin
                imem_resp <= imem_ok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
            end else begin
                imem_resp <= MEM_RESP_NOTRDY;
            end
            if (dmem_req) begin
                dmem_resp <= dmem_ok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
            end else begin
                dmem_resp <= MEM_RESP_NOTRDY;
            end
            imem_bank_q <= imem_addr[BANK_BIT];
            dmem_bank_q <= dmem_addr[BANK_BIT];
        end
    end

    // Byte offset kept for the load shift
    always_ff @(posedge clk) begin
        resp_offset <= dmem_addr[1:0];
    end

    // Read word from the bank used one cycle earlier
    assign imem_rdata = imem_bank_q ? bank1_rd_data : bank0_rd_data;
    assign bank_rdata = dmem_bank_q ? bank1_rw_rdata : bank0_rw_rdata;

endmodule

/* rtl/tcm_cfg_regs.sv */
// TCM configuration registers: write-protect limit and saturating rejected-access counter
`timescale 1ns/10ps

module tcm_cfg_regs
    import tcm_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // Host port
    input  logic              cfg_we,
    input  logic [1:0]        cfg_addr,
    input  logic [DATA_W-1:0] cfg_wdata,
    output logic [DATA_W-1:0] cfg_rdata,
    // Access control side
    input  logic              err_pulse,
    output logic [ADDR_W-1:0] wp_limit
);

    logic [DATA_W-1:0] err_count;
    logic              err_clr;

    // Any write to the count offset clears it
    assign err_clr = cfg_we && (cfg_addr == CFG_ERR_COUNT);

    // ------------------------------------------------------------
    // Write-protect limit
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wp_limit <= '0;
        end else if (cfg_we && (cfg_addr == CFG_WP_LIMIT)) begin
            wp_limit <= ADDR_W'(cfg_wdata);
        end
    end

    // ------------------------------------------------------------
    // Rejected-access counter
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_count <= '0;
        end else if (err_clr) begin
            // Clear beats a pulse in the same cycle
            err_count <= '0;
        end else if (err_pulse && (err_count != '1)) begin
            err_count <= err_count + 1'b1;
        end
    end

    // Read mux, unused offsets give zero
    always_comb begin
        case (cfg_addr)
            CFG_WP_LIMIT:  cfg_rdata = DATA_W'(wp_limit);
            CFG_ERR_COUNT: cfg_rdata = err_count;
            default:       cfg_rdata = '0;
        endcase
    end

endmodule

/* rtl/tcm_top.sv */
// TCM top level: two SRAM banks shared by the core fetch and data ports, plus config block
`timescale 1ns/10ps

module tcm_top
    import tcm_pkg::*;
#(
    parameter int TCM_SIZE = 4096
) (
    input  logic              clk,
    input  logic              rst_n,
    // Core instruction port
    output logic              imem_req_ack,
    input  logic              imem_req,
    input  logic [ADDR_W-1:0] imem_addr,
    output logic [DATA_W-1:0] imem_rdata,
    output mem_resp_e         imem_resp,
    // Core data port
    output logic              dmem_req_ack,
    input  logic              dmem_req,
    input  mem_cmd_e          dmem_cmd,
    input  mem_width_e        dmem_width,
    input  logic [ADDR_W-1:0] dmem_addr,
    input  logic [DATA_W-1:0] dmem_wdata,
    output logic [DATA_W-1:0] dmem_rdata,
    output mem_resp_e         dmem_resp,
    // Configuration port
    input  logic              cfg_we,
    input  logic [1:0]        cfg_addr,
    input  logic [DATA_W-1:0] cfg_wdata,
    output logic [DATA_W-1:0] cfg_rdata
);

    // Each bank holds half the TCM
    localparam int DEPTH = TCM_SIZE / 8;
    localparam int AW    = $clog2(DEPTH);

    // ------------------------------------------------------------
    // Internal wires
    // ------------------------------------------------------------
    logic [ADDR_W-1:0] wp_limit;
    logic              err_pulse;
    logic              misalign;
    logic [DATA_W-1:0] wr_data;
    logic [3:0]        wr_mask;
    logic [1:0]        resp_offset;
    logic [DATA_W-1:0] bank_rdata;

    // Bank 0
    logic              b0_rd_en;
    logic [AW-1:0]     b0_rd_addr;
    logic [DATA_W-1:0] b0_rd_data;
    logic              b0_rw_en;
    logic              b0_rw_we;
    logic [AW-1:0]     b0_rw_addr;
    logic [3:0]        b0_rw_mask;
    logic [DATA_W-1:0] b0_rw_rdata;

    // Bank 1
    logic              b1_rd_en;
    logic [AW-1:0]     b1_rd_addr;
    logic [DATA_W-1:0] b1_rd_data;
    logic              b1_rw_en;
    logic              b1_rw_we;
    logic [AW-1:0]     b1_rw_addr;
    logic [3:0]        b1_rw_mask;
    logic [DATA_W-1:0] b1_rw_rdata;

    // ------------------------------------------------------------
    // Access control and data lane
    // ------------------------------------------------------------
    tcm_access_ctrl #(
        .TCM_SIZE (TCM_SIZE)
    ) u_access (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .imem_req_ack   (imem_req_ack),
        .imem_resp      (imem_resp),
        .imem_rdata     (imem_rdata),
        .dmem_req       (dmem_req),
        .dmem_cmd       (dmem_cmd),
        .dmem_addr      (dmem_addr),
        .dmem_req_ack   (dmem_req_ack),
        .dmem_resp      (dmem_resp),
        .misalign       (misalign),
        .wr_mask        (wr_mask),
        .resp_offset    (resp_offset),
        .bank_rdata     (bank_rdata),
        .wp_limit       (wp_limit),
        .err_pulse      (err_pulse),
        .bank0_rd_en    (b0_rd_en),
        .bank0_rd_addr  (b0_rd_addr),
        .bank0_rd_data  (b0_rd_data),
        .bank0_rw_en    (b0_rw_en),
        .bank0_rw_we    (b0_rw_we),
        .bank0_rw_addr  (b0_rw_addr),
        .bank0_rw_mask  (b0_rw_mask),
        .bank0_rw_rdata (b0_rw_rdata),
        .bank1_rd_en    (b1_rd_en),
        .bank1_rd_addr  (b1_rd_addr),
        .bank1_rd_data  (b1_rd_data),
        .bank1_rw_en    (b1_rw_en),
        .bank1_rw_we    (b1_rw_we),
        .bank1_rw_addr  (b1_rw_addr),
        .bank1_rw_mask  (b1_rw_mask),
        .bank1_rw_rdata (b1_rw_rdata)
    );

    tcm_data_lane u_lane (
        .dmem_width   (dmem_width),
        .dmem_addr_lo (dmem_addr[1:0]),
        .dmem_wdata   (dmem_wdata),
        .wr_data      (wr_data),
        .wr_mask      (wr_mask),
        .misalign     (misalign),
        .resp_offset  (resp_offset),
        .bank_rdata   (bank_rdata),
        .dmem_rdata   (dmem_rdata)
    );

    // ------------------------------------------------------------
    // Configuration and memory banks
    // ------------------------------------------------------------
    tcm_cfg_regs u_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .err_pulse (err_pulse),
        .wp_limit  (wp_limit)
    );

    // Lower half of the address space
    tcm_sram_bank #(
        .DEPTH (DEPTH)
    ) u_bank0 (
        .clk      (clk),
        .rd_en    (b0_rd_en),
        .rd_addr  (b0_rd_addr),
        .rd_data  (b0_rd_data),
        .rw_en    (b0_rw_en),
        .rw_we    (b0_rw_we),
        .rw_addr  (b0_rw_addr),
        .rw_mask  (b0_rw_mask),
        .rw_wdata (wr_data),
        .rw_rdata (b0_rw_rdata)
    );

    // Upper half
    tcm_sram_bank #(
        .DEPTH (DEPTH)
    ) u_bank1 (
        .clk      (clk),
        .rd_en    (b1_rd_en),
        .rd_addr  (b1_rd_addr),
        .rd_data  (b1_rd_data),
        .rw_en    (b1_rw_en),
        .rw_we    (b1_rw_we),
        .rw_addr  (b1_rw_addr),
        .rw_mask  (b1_rw_mask),
        .rw_wdata (wr_data),
        .rw_rdata (b1_rw_rdata)
    );

endmodule

/* tb/tcm_tb.sv */
// Drives seeded random core traffic into the TCM top level and checks it against a byte-array model
`timescale 1ns/10ps

module tcm_tb
    import tcm_pkg::*;
;

    localparam int TCM_SIZE    = 4096;
    localparam int DRAIN_LIMIT = 8;
    localparam logic [ADDR_W-1:0] TCM_END = ADDR_W'(TCM_SIZE);

    logic              clk = 1'b0;
    logic              rst_n;
    logic              imem_req_ack;
    logic              imem_req;
    logic [ADDR_W-1:0] imem_addr;
    logic [DATA_W-1:0] imem_rdata;
    mem_resp_e         imem_resp;
    logic              dmem_req_ack;
    logic              dmem_req;
    mem_cmd_e          dmem_cmd;
    mem_width_e        dmem_width;
    logic [ADDR_W-1:0] dmem_addr;
    logic [DATA_W-1:0] dmem_wdata;
    logic [DATA_W-1:0] dmem_rdata;
    mem_resp_e         dmem_resp;
    logic              cfg_we;
    logic [1:0]        cfg_addr;
    logic [DATA_W-1:0] cfg_wdata;
    logic [DATA_W-1:0] cfg_rdata;

    // Reference model state
    logic [7:0]        ref_mem [TCM_SIZE];
    logic [ADDR_W-1:0] model_wp;
    int                model_err;
    integer            seed;

    // Expected responses with one entry per driven cycle
    mem_resp_e q_iresp[$];
    tcm_word_u q_idata[$];
    mem_resp_e q_dresp[$];
    tcm_word_u q_ddata[$];
    bit        q_dchk[$];

    tcm_top #(
        .TCM_SIZE (TCM_SIZE)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_req_ack (imem_req_ack),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .imem_resp    (imem_resp),
        .dmem_req_ack (dmem_req_ack),
        .dmem_req     (dmem_req),
        .dmem_cmd     (dmem_cmd),
        .dmem_width   (dmem_width),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_rdata   (dmem_rdata),
        .dmem_resp    (dmem_resp),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata)
    );

    // 50 MHz clock
    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // Failure handling and compare tasks
    // ------------------------------------------------------------
    task automatic abort_run;
        $display("Simulation finished: FAIL");
        $fatal(1, "first mismatch reached");
    endtask

    task automatic check_resp(input string name, input mem_resp_e exp, input mem_resp_e act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_data(input string name, input tcm_word_u exp, input tcm_word_u act);
        if (act.word !== exp.word) begin
            $display("[ERROR] %s expected %h actual %h", name, exp.word, act.word);
            abort_run();
        end
    endtask

    task automatic check_cfg(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    // Word holding a byte address assembled lane by lane
    function automatic tcm_word_u model_word(input logic [ADDR_W-1:0] addr);
        tcm_word_u w;
        int        base;
        base = int'({addr[ADDR_W-1:2], 2'b00});
        for (int i = 0; i < 4; i++) begin
            w.bytes[i] = ref_mem[base + i];
        end
        return w;
    endfunction

    function automatic bit width_aligned(input mem_width_e w, input logic [1:0] lo);
        case (w)
            MEM_WIDTH_BYTE:  return 1'b1;
            MEM_WIDTH_HWORD: return !lo[0];
            MEM_WIDTH_WORD:  return (lo == 2'b00);
            default:         return 1'b0;
        endcase
    endfunction

    // Store touches only the bytes the access covers
    task automatic model_store(input mem_width_e w, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata);
        tcm_word_u src;
        int        nbytes;
        src.word = wdata;
        nbytes   = (w == MEM_WIDTH_BYTE) ? 1 : (w == MEM_WIDTH_HWORD) ? 2 : 4;
        for (int i = 0; i < nbytes; i++) begin
            ref_mem[int'(addr) + i] = src.bytes[i];
        end
    endtask

    // Pops and checks the response to the previous cycle's requests
    task automatic check_pending;
        mem_resp_e er;
        tcm_word_u ew;
        bit        dchk;
        if (imem_req_ack !== 1'b1) begin
            $display("[ERROR] imem_req_ack expected 1 actual %h", imem_req_ack);
            abort_run();
        end
        if (dmem_req_ack !== 1'b1) begin
            $display("[ERROR] dmem_req_ack expected 1 actual %h", dmem_req_ack);
            abort_run();
        end
        if (q_iresp.size() > 1) begin
            er = q_iresp.pop_front();
            ew = q_idata.pop_front();
            check_resp("imem_resp", er, imem_resp);
            if (er == MEM_RESP_RDY_OK) begin
                check_data("imem_rdata", ew, imem_rdata);
            end
            er   = q_dresp.pop_front();
            ew   = q_ddata.pop_front();
            dchk = q_dchk.pop_front();
            check_resp("dmem_resp", er, dmem_resp);
            if (dchk) begin
                check_data("dmem_rdata", ew, dmem_rdata);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Model update then drive on the rising edge and check at the falling edge
    // ------------------------------------------------------------
    task automatic run_cycle(
        input logic ireq, input logic [ADDR_W-1:0] iaddr,
        input logic dreq, input mem_cmd_e dcmd, input mem_width_e dwidth,
        input logic [ADDR_W-1:0] daddr, input logic [DATA_W-1:0] dwdata,
        input logic cwe, input logic [1:0] caddr, input logic [DATA_W-1:0] cwdata
    );
        logic      iok;
        logic      dok;
        logic      drd;
        tcm_word_u iword;
        tcm_word_u dword;
        iok = ireq && (iaddr < TCM_END) && (iaddr[1:0] == 2'b00);
        dok = dreq && (daddr < TCM_END) && width_aligned(dwidth, daddr[1:0])
              && !((dcmd == MEM_CMD_WR) && (daddr < model_wp));
        drd = dok && (dcmd == MEM_CMD_RD);
        iword.word = '0;
        dword.word = '0;
        // Fetch sees contents before this cycle's store
        if (iok) begin
            iword = model_word(iaddr);
        end
        if (drd) begin
            dword      = model_word(daddr);
            dword.word = dword.word >> (8 * daddr[1:0]);
        end
        if (dok && (dcmd == MEM_CMD_WR)) begin
            model_store(dwidth, daddr, dwdata);
        end
        if ((ireq && !iok) || (dreq && !dok)) begin
            model_err++;
        end
        // Config write with the clear applied after the count
        if (cwe && (caddr == CFG_WP_LIMIT)) begin
            model_wp = cwdata;
        end
        if (cwe && (caddr == CFG_ERR_COUNT)) begin
            model_err = 0;
        end
        @(posedge clk);
        imem_req   <= ireq;
        imem_addr  <= iaddr;
        dmem_req   <= dreq;
        dmem_cmd   <= dcmd;
        dmem_width <= dwidth;
        dmem_addr  <= daddr;
        dmem_wdata <= dwdata;
        cfg_we     <= cwe;
        cfg_addr   <= caddr;
        cfg_wdata  <= cwdata;
        q_iresp.push_back(!ireq ? MEM_RESP_NOTRDY : iok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER);
        q_idata.push_back(iword);
        q_dresp.push_back(!dreq ? MEM_RESP_NOTRDY : dok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER);
        q_ddata.push_back(dword);
        q_dchk.push_back(drd);
        @(negedge clk);
        check_pending();
    endtask

    task automatic idle_cycle;
        run_cycle(1'b0, '0, 1'b0, MEM_CMD_RD, MEM_WIDTH_WORD, '0, '0, 1'b0, CFG_WP_LIMIT, '0);
    endtask

    task automatic write_cfg(input logic [1:0] addr, input logic [DATA_W-1:0] data);
        run_cycle(1'b0, '0, 1'b0, MEM_CMD_RD, MEM_WIDTH_WORD, '0, '0, 1'b1, addr, data);
    endtask

    // Idle cycle so the count already holds every earlier rejection
    task automatic read_cfg(input string name, input logic [1:0] addr);
        logic [31:0] exp;
        run_cycle(1'b0, '0, 1'b0, MEM_CMD_RD, MEM_WIDTH_WORD, '0, '0, 1'b0, addr, '0);
        exp = (addr == CFG_WP_LIMIT) ? model_wp : 32'(model_err);
        check_cfg(name, exp, cfg_rdata);
    endtask

    // Idle until every real response has been checked
    task automatic drain_pipeline;
        int n;
        n = 0;
        while (q_iresp[0] != MEM_RESP_NOTRDY || q_dresp[0] != MEM_RESP_NOTRDY) begin
            if (n == DRAIN_LIMIT) begin
                $display("Responses still pending after %0d idle cycles", n);
                abort_run();
            end
            idle_cycle();
            n++;
        end
    endtask

    // ------------------------------------------------------------
    // Random traffic
    // ------------------------------------------------------------
    // Mode 0 aligned words only
    // Mode 1 adds aligned bytes and halfwords
    // Mode 2 adds rejected requests
    task automatic random_cycle(input int mode);
        logic [31:0]       rnd;
        logic [ADDR_W-1:0] iaddr;
        logic [ADDR_W-1:0] daddr;
        mem_width_e        w;
        mem_cmd_e          c;
        rnd   = $random(seed);
        daddr = $random(seed) & (TCM_SIZE - 1);
        iaddr = $random(seed) & (TCM_SIZE - 4);
        c     = rnd[2] ? MEM_CMD_WR : MEM_CMD_RD;
        if (mode == 0 || rnd[4:3] == 2'b11) begin
            w = MEM_WIDTH_WORD;
        end else begin
            w = rnd[3] ? MEM_WIDTH_HWORD : MEM_WIDTH_BYTE;
        end
        if (mode < 2 || rnd[8]) begin
            daddr[1:0] = (w == MEM_WIDTH_WORD) ? 2'b00 : {daddr[1], daddr[0] & !w[0]};
        end
        // Fetch hits the word the data port touches
        if (rnd[9]) begin
            iaddr = {daddr[ADDR_W-1:2], 2'b00};
        end
        if (mode == 2) begin
            if (rnd[12:10] == 3'b000) begin
                daddr = daddr + TCM_END;
            end
            if (rnd[13]) begin
                daddr[ADDR_W-1] = rnd[14];
            end
            if (rnd[16:15] == 2'b00) begin
                iaddr = iaddr + TCM_END;
            end
            if (rnd[18:17] == 2'b00) begin
                iaddr[1:0] = rnd[20:19];
            end
        end
        run_cycle(rnd[0] | rnd[21], iaddr, rnd[1] | rnd[22], c, w, daddr, $random(seed),
                  1'b0, CFG_WP_LIMIT, '0);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        seed        = 32'h1afbc0d7;
        model_wp    = '0;
        model_err   = 0;
        rst_n       = 1'b0;
        imem_req    = 1'b0;
        imem_addr   = '0;
        dmem_req    = 1'b0;
        dmem_cmd    = MEM_CMD_RD;
        dmem_width  = MEM_WIDTH_WORD;
        dmem_addr   = '0;
        dmem_wdata  = '0;
        cfg_we      = 1'b0;
        cfg_addr    = CFG_WP_LIMIT;
        cfg_wdata   = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Quiet bus after reset
        repeat (4) idle_cycle();
        read_cfg("cfg_rdata wp_limit", CFG_WP_LIMIT);
        read_cfg("cfg_rdata err_count", CFG_ERR_COUNT);

        // Fill both banks so every later read is defined
        for (int a = 0; a < TCM_SIZE; a += 4) begin
            run_cycle(1'b0, '0, 1'b1, MEM_CMD_WR, MEM_WIDTH_WORD, 32'(a), $random(seed),
                      1'b0, CFG_WP_LIMIT, '0);
        end
        repeat (600) random_cycle(0);
        repeat (800) random_cycle(1);

        // Error traffic under a random protect limit
        write_cfg(CFG_WP_LIMIT, $random(seed) & (TCM_SIZE - 1));
        read_cfg("cfg_rdata wp_limit", CFG_WP_LIMIT);
        repeat (1000) random_cycle(2);
        drain_pipeline();
        read_cfg("cfg_rdata err_count", CFG_ERR_COUNT);

        // Clear together with a rejected fetch where the clear wins
        run_cycle(1'b1, TCM_END, 1'b0, MEM_CMD_RD, MEM_WIDTH_WORD, '0, '0,
                  1'b1, CFG_ERR_COUNT, 32'hffff_ffff);
        read_cfg("cfg_rdata err_count", CFG_ERR_COUNT);

        // Full readback on both ports
        for (int a = 0; a < TCM_SIZE; a += 4) begin
            run_cycle(1'b1, 32'(a), 1'b1, MEM_CMD_RD, MEM_WIDTH_WORD, 32'(a), '0,
                      1'b0, CFG_WP_LIMIT, '0);
        end
        drain_pipeline();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* sim.f */
rtl/tcm_pkg.sv
rtl/tcm_sram_bank.sv
rtl/tcm_data_lane.sv
rtl/tcm_access_ctrl.sv
rtl/tcm_cfg_regs.sv
rtl/tcm_top.sv
tb/tcm_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the TCM testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module tcm_tb -o tcm_sim > sim.log 2>&1 \
    && ./obj_dir/tcm_sim >> sim.log 2>&1 \
    || echo "Simulation finished: FAIL" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log \
    && { echo "TCM simulation failed"; exit 1; } \
    || grep -q "Simulation finished: PASS" sim.log \
    || { echo "TCM simulation ended without a result"; exit 1; }
